/* project.f */
secp256k1_curve_pkg.sv
secp256k1_cmd_pkg.sv
mod_inverse.sv
mod_mult.sv
sig_cmd_decoder.sv
sig_scalar_engine.sv
sig_reply_serializer.sv
secp256k1_top.sv
tb_secp256k1_top.sv

/* Bender.yml */
package:
  name: secp256k1_verify

sources:
  - secp256k1_curve_pkg.sv
  - secp256k1_cmd_pkg.sv
  - mod_inverse.sv
  - mod_mult.sv
  - sig_cmd_decoder.sv
  - sig_scalar_engine.sv
  - sig_reply_serializer.sv
  - secp256k1_top.sv
  - target: test
    files:
      - tb_secp256k1_top.sv

/* tb_secp256k1_top.sv */
`timescale 1ns/1ps

module tb_secp256k1_top import secp256k1_curve_pkg::*, secp256k1_cmd_pkg::*;;

  localparam int          NUM_TESTS   = 16;
  localparam int          REPLY_WORDS = 11;
  localparam logic [15:0] CMD_UNKNOWN = 16'h0200;

  logic        i_clk = 1'b0;
  logic        i_rst;
  logic [63:0] i_rx_dat;
  logic        i_rx_val, i_rx_sop, i_rx_eop;
  logic        o_rx_rdy;
  logic [63:0] o_tx_dat;
  logic        o_tx_val, o_tx_sop, o_tx_eop;
  logic [2:0]  o_tx_mod;
  logic        i_tx_rdy;

  int          seed = 32'h04bee2c0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_num = 0;
  int          expected_replies = 0;
  int          replies_done = 0;
  int          word_idx = 0;
  bit          rdy_random = 1'b0;
  logic [63:0] cur_rpl [REPLY_WORDS];
  logic [63:0] last_rpl [REPLY_WORDS];

  secp256k1_top dut (
    .i_clk    ( i_clk    ),
    .i_rst    ( i_rst    ),
    .i_rx_dat ( i_rx_dat ),
    .i_rx_val ( i_rx_val ),
    .i_rx_sop ( i_rx_sop ),
    .i_rx_eop ( i_rx_eop ),
    .o_rx_rdy ( o_rx_rdy ),
    .o_tx_dat ( o_tx_dat ),
    .o_tx_val ( o_tx_val ),
    .o_tx_sop ( o_tx_sop ),
    .o_tx_eop ( o_tx_eop ),
    .o_tx_mod ( o_tx_mod ),
    .i_tx_rdy ( i_tx_rdy )
  );

  always #10 i_clk = ~i_clk;

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  function automatic logic [255:0] mul_mod_n(input logic [255:0] a, input logic [255:0] b);
    logic [511:0] p;
    p = {256'd0, a} * {256'd0, b};
    p = p % {256'd0, CURVE_N};
    return p[255:0];
  endfunction

  // n is prime, so a^(n-2) is the inverse
  function automatic logic [255:0] inv_mod_n(input logic [255:0] a);
    logic [255:0] e;
    logic [255:0] base;
    logic [255:0] acc;
    int           i;
    e    = CURVE_N - 256'd2;
    base = a;
    acc  = 256'd1;
    for (i = 0; i < 256; i++) begin
      if (e[i]) acc = mul_mod_n(acc, base);
      base = mul_mod_n(base, base);
    end
    return acc;
  endfunction

  function automatic logic [255:0] rand256();
    logic [255:0] v;
    int           k;
    for (k = 0; k < 8; k++) v[k*32 +: 32] = $random(seed);
    return v;
  endfunction

  function automatic logic [255:0] rand_in_range();
    logic [255:0] v;
    v = rand256() % CURVE_N;
    return (v == '0) ? 256'd1 : v;
  endfunction

  // Somewhere from n up to 2^256 - 1
  function automatic logic [255:0] rand_above_n();
    return CURVE_N + (rand256() % (256'd0 - CURVE_N));
  endfunction

  task automatic send_word(input logic [63:0] d, input logic sop, input logic eop);
    i_rx_dat <= d;
    i_rx_val <= 1'b1;
    i_rx_sop <= sop;
    i_rx_eop <= eop;
    @(posedge i_clk);
    while (!o_rx_rdy) @(posedge i_clk);
  endtask

  task automatic end_packet();
    i_rx_val <= 1'b0;
    i_rx_sop <= 1'b0;
    i_rx_eop <= 1'b0;
  endtask

  task automatic send_verify(input logic [63:0] index, input logic [255:0] s,
                             input logic [255:0] r, input logic [255:0] z);
    logic [1279:0] data;
    int            k;
    // Q is random filler in the last eight words
    data = {rand256(), rand256(), z, r, s};
    send_word({16'h0100, 32'((CMD_DATA_WORDS + 2) * 8), 16'd0}, 1'b1, 1'b0);
    send_word(index, 1'b0, 1'b0);
    for (k = 0; k < 20; k++) send_word(data[k*64 +: 64], 1'b0, k == 19);
    end_packet();
  endtask

  task automatic send_unknown();
    int len;
    int k;
    len = {$random(seed)} % 8;
    send_word({CMD_UNKNOWN, 32'((len + 1) * 8), 16'd0}, 1'b1, len == 0);
    for (k = 0; k < len; k++) send_word({$random(seed), $random(seed)}, 1'b0, k == len - 1);
    end_packet();
  endtask

  // Flag bit 1 is s out of range, bit 0 is r out of range
  task automatic run_verify(input string name, input logic [1:0] exp_flags,
                            input logic [255:0] s, input logic [255:0] r,
                            input logic [255:0] z);
    logic [63:0]  index;
    logic [255:0] w;
    logic [255:0] exp_u1;
    logic [255:0] exp_u2;
    int           err_start;
    err_start = errors;
    test_num++;
    index  = {$random(seed), $random(seed)};
    exp_u1 = '0;
    exp_u2 = '0;
    if (exp_flags == 2'b00) begin
      w      = inv_mod_n(s);
      exp_u1 = mul_mod_n(z, w);
      exp_u2 = mul_mod_n(r, w);
    end
    expected_replies++;
    send_verify(index, s, r, z);
    wait (replies_done == expected_replies);
    assert (last_rpl[0][63:48] == 16'h0101) else report_error("reply header code wrong");
    assert (last_rpl[0][47:16] == 32'd88) else report_error("reply length wrong");
    assert (last_rpl[1] == index)
      else report_error($sformatf("index got %h expected %h", last_rpl[1], index));
    assert (last_rpl[2] == {62'd0, exp_flags})
      else report_error($sformatf("flags got %h", last_rpl[2]));
    assert ({last_rpl[6], last_rpl[5], last_rpl[4], last_rpl[3]} == exp_u1)
      else report_error($sformatf("u1 wrong, expected %h", exp_u1));
    assert ({last_rpl[10], last_rpl[9], last_rpl[8], last_rpl[7]} == exp_u2)
      else report_error($sformatf("u2 wrong, expected %h", exp_u2));
    @(posedge i_clk);
    if (errors == err_start) begin
      tests_passed++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED", test_num, name);
    end
  endtask

  // Collects reply words as they are accepted
  always @(posedge i_clk) begin
    if (!i_rst && o_tx_val && i_tx_rdy) begin
      assert (o_tx_sop == (word_idx == 0)) else report_error("sop misplaced in reply");
      assert (o_tx_eop == (word_idx == REPLY_WORDS - 1))
        else report_error("eop misplaced in reply");
      if (word_idx < REPLY_WORDS) cur_rpl[word_idx] = o_tx_dat;
      if (o_tx_eop) begin
        last_rpl = cur_rpl;
        word_idx = 0;
        replies_done++;
      end else begin
        word_idx++;
      end
    end
  end

  always @(posedge i_clk) begin
    if (rdy_random) i_tx_rdy <= 1'($random(seed));
    else i_tx_rdy <= 1'b1;
  end

  a_tx_stall: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_tx_val && !i_tx_rdy) |=>
      (o_tx_val && $stable(o_tx_dat) && $stable(o_tx_sop) && $stable(o_tx_eop)))
    else report_error("reply word changed while stalled");

  a_tx_mod: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val |-> (o_tx_mod == 3'd0))
    else report_error("o_tx_mod not zero");

  initial begin
    #(NUM_TESTS * 4000 * 20);
    $display("Timeout: the run hung, a reply never completed");
    $display("Regression failed");
    $finish;
  end

  initial begin
    int k;
    i_rst    = 1'b1;
    i_rx_dat = '0;
    i_rx_val = 1'b0;
    i_rx_sop = 1'b0;
    i_rx_eop = 1'b0;
    i_tx_rdy = 1'b1;
    repeat (8) @(posedge i_clk);
    assert (!o_rx_rdy && !o_tx_val) else report_error("stream outputs active in reset");
    i_rst <= 1'b0;
    @(posedge i_clk);

    for (k = 0; k < 4; k++) begin
      run_verify("in range", 2'b00, rand_in_range(), rand_in_range(), rand256());
    end
    run_verify("s zero", 2'b10, '0, rand_in_range(), rand256());
    run_verify("s equal n", 2'b10, CURVE_N, rand_in_range(), rand256());
    run_verify("s above n", 2'b10, rand_above_n(), rand_in_range(), rand256());
    run_verify("r zero", 2'b01, rand_in_range(), '0, rand256());
    run_verify("r equal n", 2'b01, rand_in_range(), CURVE_N, rand256());
    run_verify("r above n", 2'b01, rand_in_range(), rand_above_n(), rand256());
    for (k = 0; k < 2; k++) begin
      send_unknown();
      run_verify("after unknown cmd", 2'b00, rand_in_range(), rand_in_range(), rand256());
    end
    rdy_random = 1'b1;
    for (k = 0; k < 3; k++) begin
      run_verify("tx stalls", 2'b00, rand_in_range(), rand_in_range(), rand256());
    end
    run_verify("tx stalls rejected", 2'b10, rand_above_n(), rand_in_range(), rand256());
    rdy_random = 1'b0;

    // Give a stray reply time to show up
    repeat (50) @(posedge i_clk);
    assert (replies_done == expected_replies) else report_error("reply count differs");
    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* secp256k1_top.sv */
`timescale 1ns/1ps

module secp256k1_top import secp256k1_curve_pkg::*, secp256k1_cmd_pkg::*; (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic [WORD_BITS-1:0]          i_rx_dat,
  input  logic                          i_rx_val,
  input  logic                          i_rx_sop,
  input  logic                          i_rx_eop,
  output logic                          o_rx_rdy,
  output logic [WORD_BITS-1:0]          o_tx_dat,
  output logic                          o_tx_val,
  output logic                          o_tx_sop,
  output logic                          o_tx_eop,
  output logic [$clog2(WORD_BYTES)-1:0] o_tx_mod,
  input  logic                          i_tx_rdy
);

  logic                   op_val, eng_busy, res_val, rpl_busy;
  logic [SCALAR_BITS-1:0] s, r, z, u1, u2;
  logic [WORD_BITS-1:0]   op_index, res_index;
  check_flags_t           flags;

  sig_cmd_decoder u_dec (
    .i_clk    ( i_clk    ),
    .i_rst    ( i_rst    ),
    .i_rx_dat ( i_rx_dat ),
    .i_rx_val ( i_rx_val ),
    .i_rx_sop ( i_rx_sop ),
    .i_rx_eop ( i_rx_eop ),
    .i_busy   ( eng_busy ),
    .o_rx_rdy ( o_rx_rdy ),
    .o_op_val ( op_val   ),
    .o_s      ( s        ),
    .o_r      ( r        ),
    .o_z      ( z        ),
    .o_index  ( op_index )
  );

  sig_scalar_engine u_eng (
    .i_clk      ( i_clk     ),
    .i_rst      ( i_rst     ),
    .i_op_val   ( op_val    ),
    .i_s        ( s         ),
    .i_r        ( r         ),
    .i_z        ( z         ),
    .i_index    ( op_index  ),
    .i_rpl_busy ( rpl_busy  ),
    .o_busy     ( eng_busy  ),
    .o_res_val  ( res_val   ),
    .o_u1       ( u1        ),
    .o_u2       ( u2        ),
    .o_flags    ( flags     ),
    .o_index    ( res_index )
  );

  sig_reply_serializer u_ser (
    .i_clk     ( i_clk     ),
    .i_rst     ( i_rst     ),
    .i_res_val ( res_val   ),
    .i_u1      ( u1        ),
    .i_u2      ( u2        ),
    .i_flags   ( flags     ),
    .i_index   ( res_index ),
    .i_tx_rdy  ( i_tx_rdy  ),
    .o_busy    ( rpl_busy  ),
    .o_tx_dat  ( o_tx_dat  ),
    .o_tx_val  ( o_tx_val  ),
    .o_tx_sop  ( o_tx_sop  ),
    .o_tx_eop  ( o_tx_eop  ),
    .o_tx_mod  ( o_tx_mod  )
  );

endmodule

/* sig_reply_serializer.sv */
`timescale 1ns/1ps

module sig_reply_serializer import secp256k1_curve_pkg::*, secp256k1_cmd_pkg::*; (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_res_val,
  input  logic [SCALAR_BITS-1:0]        i_u1,
  input  logic [SCALAR_BITS-1:0]        i_u2,
  input  check_flags_t                  i_flags,
  input  logic [WORD_BITS-1:0]          i_index,
  input  logic                          i_tx_rdy,
  output logic                          o_busy,
  output logic [WORD_BITS-1:0]          o_tx_dat,
  output logic                          o_tx_val,
  output logic                          o_tx_sop,
  output logic                          o_tx_eop,
  output logic [$clog2(WORD_BYTES)-1:0] o_tx_mod
);

  logic [RPL_WORDS-1:0][WORD_BITS-1:0] sr;
  logic [3:0]                          cnt;
  logic                                xfer;
  logic                                load;
  cmd_word_u                           hdr_w;

  always_comb begin
    hdr_w.hdr.cmd   = CMD_VERIFY_SIG_RPL;
    hdr_w.hdr.len   = 32'(RPL_BYTES);
    hdr_w.hdr.spare = '0;
  end

  assign load     = i_res_val && !o_tx_val;
  assign xfer     = o_tx_val && i_tx_rdy;
  assign o_busy   = o_tx_val;
  assign o_tx_dat = sr[0];
  assign o_tx_sop = (cnt == '0);
  assign o_tx_eop = (cnt == 4'(RPL_WORDS - 1));
  // Reply is a whole number of words
  assign o_tx_mod = '0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_tx_val <= 1'b0;
      cnt      <= '0;
    end else if (load) begin
      o_tx_val <= 1'b1;
      cnt      <= '0;
    end else if (xfer) begin
      cnt <= cnt + 4'd1;
      if (o_tx_eop) o_tx_val <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      sr <= {i_u2, i_u1,
             {{(WORD_BITS-$bits(check_flags_t)){1'b0}}, i_flags},
             i_index, hdr_w.raw};
    end else if (xfer) begin
      sr <= sr >> WORD_BITS;
    end
  end

  // A new result never lands while a reply is still going out
  a_no_result_lost: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val |-> !o_tx_val);

endmodule

/* sig_scalar_engine.sv */
`timescale 1ns/1ps

module sig_scalar_engine import secp256k1_curve_pkg::*, secp256k1_cmd_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_op_val,
  input  logic [SCALAR_BITS-1:0] i_s,
  input  logic [SCALAR_BITS-1:0] i_r,
  input  logic [SCALAR_BITS-1:0] i_z,
  input  logic [WORD_BITS-1:0]   i_index,
  input  logic                   i_rpl_busy,
  output logic                   o_busy,
  output logic                   o_res_val,
  output logic [SCALAR_BITS-1:0] o_u1,
  output logic [SCALAR_BITS-1:0] o_u2,
  output check_flags_t           o_flags,
  output logic [WORD_BITS-1:0]   o_index
);

  typedef enum logic [1:0] {IDLE, INV, MUL_U1, MUL_U2} state_t;

  state_t                 state;
  logic [SCALAR_BITS-1:0] s_q, r_q, z_q, u1_q;
  logic [SCALAR_BITS-1:0] w, prod, mul_a;
  logic [WORD_BITS-1:0]   idx_q;
  logic                   inv_start, inv_done, mul_start, mul_done;
  logic                   accept;
  check_flags_t           in_flags;

  assign in_flags.out_of_range_s = (i_s == '0) || (i_s >= CURVE_N);
  assign in_flags.out_of_range_r = (i_r == '0) || (i_r >= CURVE_N);

  assign accept = i_op_val && (state == IDLE) && !o_res_val && !i_rpl_busy;
  assign o_busy = (state != IDLE) || i_op_val || o_res_val || i_rpl_busy;
  // Multiplier b input is always w while a picks z for u1 and r for u2
  assign mul_a  = (state == MUL_U2) ? r_q : z_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      inv_start <= 1'b0;
      mul_start <= 1'b0;
      o_res_val <= 1'b0;
    end else begin
      inv_start <= 1'b0;
      mul_start <= 1'b0;
      o_res_val <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            if (|in_flags) begin
              o_res_val <= 1'b1;
            end else begin
              inv_start <= 1'b1;
              state     <= INV;
            end
          end
        end
        INV: begin
          if (inv_done) begin
            mul_start <= 1'b1;
            state     <= MUL_U1;
          end
        end
        MUL_U1: begin
          if (mul_done) begin
            mul_start <= 1'b1;
            state     <= MUL_U2;
          end
        end
        MUL_U2: begin
          if (mul_done) begin
            o_res_val <= 1'b1;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      s_q   <= i_s;
      r_q   <= i_r;
      z_q   <= i_z;
      idx_q <= i_index;
    end
    if (state == MUL_U1 && mul_done) u1_q <= prod;
    // Results only change together with o_res_val
    if (accept && (|in_flags)) begin
      o_u1    <= '0;
      o_u2    <= '0;
      o_flags <= in_flags;
      o_index <= i_index;
    end else if (state == MUL_U2 && mul_done) begin
      o_u1    <= u1_q;
      o_u2    <= prod;
      o_flags <= '0;
      o_index <= idx_q;
    end
  end

  mod_inverse u_inv (
    .i_clk   ( i_clk     ),
    .i_rst   ( i_rst     ),
    .i_start ( inv_start ),
    .i_a     ( s_q       ),
    .o_done  ( inv_done  ),
    .o_inv   ( w         )
  );

  mod_mult u_mult (
    .i_clk   ( i_clk     ),
    .i_rst   ( i_rst     ),
    .i_start ( mul_start ),
    .i_a     ( mul_a     ),
    .i_b     ( w         ),
    .o_done  ( mul_done  ),
    .o_prod  ( prod      )
  );

  // Operands arrive only when the engine can take them
  a_op_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    i_op_val |-> accept);

endmodule

/* sig_cmd_decoder.sv */
`timescale 1ns/1ps

module sig_cmd_decoder import secp256k1_curve_pkg::*, secp256k1_cmd_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  cmd_word_u              i_rx_dat,
  input  logic                   i_rx_val,
  input  logic                   i_rx_sop,
  input  logic                   i_rx_eop,
  input  logic                   i_busy,
  output logic                   o_rx_rdy,
  output logic                   o_op_val,
  output logic [SCALAR_BITS-1:0] o_s,
  output logic [SCALAR_BITS-1:0] o_r,
  output logic [SCALAR_BITS-1:0] o_z,
  output logic [WORD_BITS-1:0]   o_index
);

  typedef enum logic [1:0] {IDLE, GET_INDEX, PARSE, DRAIN} state_t;

  state_t     state;
  logic [4:0] cnt;
  logic       xfer;
  logic       last_xfer;

  assign xfer      = i_rx_val && o_rx_rdy;
  assign last_xfer = xfer && (state == PARSE) && (cnt == 5'(CMD_DATA_WORDS - 1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= IDLE;
      cnt      <= '0;
      o_rx_rdy <= 1'b0;
      o_op_val <= 1'b0;
    end else begin
      o_op_val <= last_xfer;
      // Stall input until the engine has picked up the operands and the reply is out
      o_rx_rdy <= !(i_busy || o_op_val || last_xfer);
      case (state)
        IDLE: begin
          cnt <= '0;
          if (xfer && i_rx_sop) begin
            if (i_rx_dat.hdr.cmd == CMD_VERIFY_SIG) begin
              state <= GET_INDEX;
            end else if (!i_rx_eop) begin
              state <= DRAIN;
            end
          end
        end
        GET_INDEX: begin
          if (xfer) state <= PARSE;
        end
        PARSE: begin
          if (xfer) begin
            cnt <= cnt + 5'd1;
            if (last_xfer) state <= IDLE;
          end
        end
        DRAIN: begin
          if (xfer && i_rx_eop) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (xfer && state == GET_INDEX) o_index <= i_rx_dat.raw;
    // Words 12 to 19 carry Q and are dropped
    if (xfer && state == PARSE && !cnt[4]) begin
      case (cnt[3:2])
        2'd0: o_s[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_rx_dat.raw;
        2'd1: o_r[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_rx_dat.raw;
        2'd2: o_z[cnt[1:0]*WORD_BITS +: WORD_BITS] <= i_rx_dat.raw;
        default: ;
      endcase
    end
  end

  a_op_val_when_free: assert property (@(posedge i_clk) disable iff (i_rst)
    o_op_val |-> $past(!i_busy));

endmodule

/* mod_mult.sv */
`timescale 1ns/1ps

module mod_mult import secp256k1_curve_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  logic [SCALAR_BITS-1:0] i_a,
  input  logic [SCALAR_BITS-1:0] i_b,
  output logic                   o_done,
  output logic [SCALAR_BITS-1:0] o_prod
);

  logic [SCALAR_BITS-1:0]         a_q, b_q;
  logic [SCALAR_BITS+1:0]         sum, red1, red2;
  logic [$clog2(SCALAR_BITS)-1:0] cnt;
  logic                           busy;

  // 2*acc + a stays below 3n, so two subtractions bring it back under n
  always_comb begin
    sum  = {1'b0, o_prod, 1'b0} + (b_q[SCALAR_BITS-1] ? {2'b00, a_q} : '0);
    red1 = (sum >= {2'b00, CURVE_N}) ? (sum - {2'b00, CURVE_N}) : sum;
    red2 = (red1 >= {2'b00, CURVE_N}) ? (red1 - {2'b00, CURVE_N}) : red1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
      cnt    <= '0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (&cnt) begin
          busy   <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      // Hash values may exceed n but stay below 2n
      a_q    <= (i_a >= CURVE_N) ? (i_a - CURVE_N) : i_a;
      b_q    <= i_b;
      o_prod <= '0;
    end else if (busy) begin
      o_prod <= red2[SCALAR_BITS-1:0];
      b_q    <= b_q << 1;
    end
  end

endmodule

/* mod_inverse.sv */
`timescale 1ns/1ps

module mod_inverse import secp256k1_curve_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_start,
  input  logic [SCALAR_BITS-1:0] i_a,
  output logic                   o_done,
  output logic [SCALAR_BITS-1:0] o_inv
);

  logic [SCALAR_BITS-1:0] u, v, x1, x2;
  logic                   busy;
  logic                   found;

  // An odd x is made even by adding the odd n before halving
  function automatic logic [SCALAR_BITS-1:0] half_mod(input logic [SCALAR_BITS-1:0] x);
    logic [SCALAR_BITS:0] t;
    t = x[0] ? ({1'b0, x} + {1'b0, CURVE_N}) : {1'b0, x};
    return t[SCALAR_BITS:1];
  endfunction

  function automatic logic [SCALAR_BITS-1:0] sub_mod(input logic [SCALAR_BITS-1:0] a,
                                                     input logic [SCALAR_BITS-1:0] b);
    return (a >= b) ? (a - b) : (a - b + CURVE_N);
  endfunction

  assign found = (u == SCALAR_BITS'(1)) || (v == SCALAR_BITS'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
      end else if (busy && found) begin
        busy   <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      u  <= i_a;
      v  <= CURVE_N;
      x1 <= SCALAR_BITS'(1);
      x2 <= '0;
    end else if (busy) begin
      if (found) begin
        o_inv <= (u == SCALAR_BITS'(1)) ? x1 : x2;
      end else if (!u[0] || !v[0]) begin
        // Both halvings may happen in the same cycle
        if (!u[0]) begin
          u  <= u >> 1;
          x1 <= half_mod(x1);
        end
        if (!v[0]) begin
          v  <= v >> 1;
          x2 <= half_mod(x2);
        end
      end else if (u >= v) begin
        u  <= u - v;
        x1 <= sub_mod(x1, x2);
      end else begin
        v  <= v - u;
        x2 <= sub_mod(x2, x1);
      end
    end
  end

  a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
    busy |-> !i_start);

endmodule

/* secp256k1_cmd_pkg.sv */
package secp256k1_cmd_pkg;

  localparam int WORD_BITS  = 64;
  localparam int WORD_BYTES = 8;

  typedef struct packed {
    logic [15:0] cmd;
    // Message length in bytes
    logic [31:0] len;
    logic [15:0] spare;
  } cmd_hdr_t;

  // First word of a packet is a header and the rest are plain data
  typedef union packed {
    cmd_hdr_t             hdr;
    logic [WORD_BITS-1:0] raw;
  } cmd_word_u;

  localparam logic [15:0] CMD_VERIFY_SIG     = 16'h0100;
  localparam logic [15:0] CMD_VERIFY_SIG_RPL = 16'h0101;

  // s, r, z and Q after the index word
  localparam int CMD_DATA_WORDS = 20;

  // Header, index, flags, u1 and u2
  localparam int RPL_WORDS = 11;
  localparam int RPL_BYTES = RPL_WORDS * WORD_BYTES;

endpackage

/* secp256k1_curve_pkg.sv */
package secp256k1_curve_pkg;

  localparam int SCALAR_BITS = 256;

  // Order of the secp256k1 base point
  localparam logic [SCALAR_BITS-1:0] CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  // Range check results returned to the host
  typedef struct packed {
    logic out_of_range_s;
    logic out_of_range_r;
  } check_flags_t;

endpackage
